//--- logic/axiLitePkg.sv
package axiLitePkg;

  // bus geometry
  localparam int addrWidth = 8;
  localparam int dataWidth = 32;
  localparam int strbWidth = dataWidth / 8;

  // register map
  localparam int regCount = 8;
  localparam int idxWidth = $clog2(regCount);
  localparam int privFirstIdx = 4;                   // regs 4..7 need prot[0]

  localparam logic [dataWidth-1:0] idValue = 32'hA411_0001;
  localparam logic [dataWidth-1:0] resetValue = '0;

  // AXI response codes, EXOKAY and DECERR never issued
  typedef enum logic [1:0] {
    respOkay = 2'b00,
    respSlvErr = 2'b10
  } respType;

  typedef enum logic [1:0] {
    wIdle,                                           // both halves accepted
    wAddrHeld,                                       // address in, waiting on data
    wDataHeld,                                       // data in, waiting on address
    wResp                                            // B channel pending
  } writeStateType;

  typedef enum logic {
    rIdle,
    rResp
  } readStateType;

endpackage

//--- logic/regAddrDecode.sv
`timescale 1ns/10ps

module regAddrDecode (
  input  logic [axiLitePkg::addrWidth-1:0] addr,
  input  logic [2:0]                       prot,
  output logic [axiLitePkg::idxWidth-1:0]  regIdx,
  output logic                             accessErr
);

  logic outOfMap;
  logic misaligned;
  logic privErr;

  // word index sits just above the byte offset
  assign regIdx = addr[axiLitePkg::idxWidth+1:2];

  // anything above 0x1C falls outside the bank
  assign outOfMap = |addr[axiLitePkg::addrWidth-1:axiLitePkg::idxWidth+2];

  assign misaligned = |addr[1:0];

  // only prot[0] is decoded, prot[2:1] are don't care here
  assign privErr = (int'(regIdx) >= axiLitePkg::privFirstIdx) && !prot[0];

  assign accessErr = outOfMap || misaligned || privErr;

endmodule

//--- logic/regBank.sv
`timescale 1ns/10ps

module regBank (
  input  logic                             aclk,
  input  logic                             rstN,
  // write port
  input  logic                             writeEn,
  input  logic [axiLitePkg::idxWidth-1:0]  wrIdx,
  input  logic [axiLitePkg::dataWidth-1:0] wrData,
  input  logic [axiLitePkg::strbWidth-1:0] wrStrb,
  // read port
  input  logic                             readEn,
  input  logic [axiLitePkg::idxWidth-1:0]  rdIdx,
  input  logic                             rdErr,
  output logic [axiLitePkg::dataWidth-1:0] rdata
);

  // index 0 is the ID constant, no storage behind it
  logic [axiLitePkg::dataWidth-1:0] regs [1:axiLitePkg::regCount-1];

  logic [axiLitePkg::dataWidth-1:0] oldWord;
  logic [axiLitePkg::dataWidth-1:0] mergedWord;
  logic [axiLitePkg::dataWidth-1:0] rdWord;
  logic                             wrHit;

  assign wrHit = writeEn && (wrIdx != '0);

  // current contents of the write target
  always_comb begin
    if (wrIdx == '0) begin
      oldWord = axiLitePkg::idValue;
    end else begin
      oldWord = regs[wrIdx];
    end
  end

  // byte lanes with a strobe take the new data
  always_comb begin
    mergedWord = oldWord;
    for (int b = 0; b < axiLitePkg::strbWidth; b++) begin
      if (wrStrb[b]) begin
        mergedWord[8*b +: 8] = wrData[8*b +: 8];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (!rstN) begin
      for (int i = 1; i < axiLitePkg::regCount; i++) begin
        regs[i] <= axiLitePkg::resetValue;
      end
    end else if (wrHit) begin
      regs[wrIdx] <= mergedWord;
    end
  end

  always_comb begin
    if (rdIdx == '0) begin
      rdWord = axiLitePkg::idValue;
    end else begin
      rdWord = regs[rdIdx];
    end
  end

  // sampled on the AR edge, so a write landing on the same edge is not seen
  always_ff @(posedge aclk) begin
    if (readEn) begin
      if (rdErr) begin
        rdata <= '0;
      end else begin
        rdata <= rdWord;
      end
    end
  end

endmodule

//--- logic/axiLiteSlaveCtrl.sv
`timescale 1ns/10ps

module axiLiteSlaveCtrl (
  input  logic                                 aclk,
  input  logic                                 rstN,
  // write address / data / response
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [axiLitePkg::addrWidth-1:0]     awaddr,
  input  logic [2:0]                           awprot,
  input  logic                                 wvalid,
  output logic                                 wready,
  input  logic [axiLitePkg::dataWidth-1:0]     wdata,
  input  logic [axiLitePkg::strbWidth-1:0]     wstrb,
  output logic                                 bvalid,
  input  logic                                 bready,
  output axiLitePkg::respType                  bresp,
  // read address / data
  input  logic                                 arvalid,
  output logic                                 arready,
  input  logic [axiLitePkg::addrWidth-1:0]     araddr,
  input  logic [2:0]                           arprot,
  output logic                                 rvalid,
  input  logic                                 rready,
  output axiLitePkg::respType                  rresp,
  // decoder side
  output logic [axiLitePkg::addrWidth-1:0]     wrAddr,
  output logic [2:0]                           wrProt,
  input  logic [axiLitePkg::idxWidth-1:0]      wrIdx,
  input  logic                                 wrErr,
  output logic [axiLitePkg::addrWidth-1:0]     rdAddr,
  output logic [2:0]                           rdProt,
  input  logic                                 rdErr,
  // register bank side
  output logic                                 writeEn,
  output logic [axiLitePkg::dataWidth-1:0]     wrData,
  output logic [axiLitePkg::strbWidth-1:0]     wrStrb,
  output logic                                 readEn
);

  axiLitePkg::writeStateType wState;
  axiLitePkg::writeStateType wStateNext;
  axiLitePkg::readStateType  rState;
  axiLitePkg::readStateType  rStateNext;

  logic                             awFire;
  logic                             wFire;
  logic                             bFire;
  logic                             arFire;
  logic                             rFire;
  logic                             wrDone;
  logic                             wrFault;

  logic [axiLitePkg::addrWidth-1:0] awAddrReg;
  logic [2:0]                       awProtReg;
  logic [axiLitePkg::dataWidth-1:0] wDataReg;
  logic [axiLitePkg::strbWidth-1:0] wStrbReg;
  logic [axiLitePkg::addrWidth-1:0] arAddrReg;
  logic [2:0]                       arProtReg;

  // write channel handshakes
  assign awready = (wState == axiLitePkg::wIdle) || (wState == axiLitePkg::wDataHeld);
  assign wready  = (wState == axiLitePkg::wIdle) || (wState == axiLitePkg::wAddrHeld);
  assign bvalid  = (wState == axiLitePkg::wResp);

  assign awFire = awvalid && awready;
  assign wFire  = wvalid && wready;
  assign bFire  = bvalid && bready;

  // second half of the write arrives this cycle
  assign wrDone = (awFire && wFire) ||
                  (awFire && (wState == axiLitePkg::wDataHeld)) ||
                  (wFire && (wState == axiLitePkg::wAddrHeld));

  // live channel unless that half was taken earlier
  assign wrAddr = (wState == axiLitePkg::wAddrHeld) ? awAddrReg : awaddr;
  assign wrProt = (wState == axiLitePkg::wAddrHeld) ? awProtReg : awprot;
  assign wrData = (wState == axiLitePkg::wDataHeld) ? wDataReg : wdata;
  assign wrStrb = (wState == axiLitePkg::wDataHeld) ? wStrbReg : wstrb;

  assign wrFault = wrErr || (wrIdx == '0);          // ID word is read only
  assign writeEn = wrDone && !wrFault;

  // read channel handshakes
  assign arready = (rState == axiLitePkg::rIdle);
  assign rvalid  = (rState == axiLitePkg::rResp);
  assign arFire  = arvalid && arready;
  assign rFire   = rvalid && rready;
  assign readEn  = arFire;

  assign rdAddr = (rState == axiLitePkg::rIdle) ? araddr : arAddrReg;
  assign rdProt = (rState == axiLitePkg::rIdle) ? arprot : arProtReg;

  always_comb begin
    wStateNext = wState;
    case (wState)
      axiLitePkg::wIdle: begin
        if (wrDone) begin
          wStateNext = axiLitePkg::wResp;
        end else if (awFire) begin
          wStateNext = axiLitePkg::wAddrHeld;
        end else if (wFire) begin
          wStateNext = axiLitePkg::wDataHeld;
        end
      end
      axiLitePkg::wAddrHeld,
      axiLitePkg::wDataHeld: begin
        if (wrDone) wStateNext = axiLitePkg::wResp;
      end
      axiLitePkg::wResp: begin
        if (bFire) wStateNext = axiLitePkg::wIdle;
      end
      default: wStateNext = axiLitePkg::wIdle;
    endcase
  end

  always_comb begin
    rStateNext = rState;
    case (rState)
      axiLitePkg::rIdle: if (arFire) rStateNext = axiLitePkg::rResp;
      axiLitePkg::rResp: if (rFire) rStateNext = axiLitePkg::rIdle;
      default:           rStateNext = axiLitePkg::rIdle;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!rstN) begin
      wState <= axiLitePkg::wIdle;
      rState <= axiLitePkg::rIdle;
      bresp  <= axiLitePkg::respOkay;
      rresp  <= axiLitePkg::respOkay;
    end else begin
      wState <= wStateNext;
      rState <= rStateNext;
      if (wrDone) begin
        if (wrFault) bresp <= axiLitePkg::respSlvErr;
        else         bresp <= axiLitePkg::respOkay;
      end
      if (arFire) begin
        if (rdErr) rresp <= axiLitePkg::respSlvErr;
        else       rresp <= axiLitePkg::respOkay;
      end
    end
  end

  // captured channel payloads
  always_ff @(posedge aclk) begin
    if (awFire) begin
      awAddrReg <= awaddr;
      awProtReg <= awprot;
    end
    if (wFire) begin
      wDataReg <= wdata;
      wStrbReg <= wstrb;
    end
    if (arFire) begin
      arAddrReg <= araddr;
      arProtReg <= arprot;
    end
  end

endmodule

//--- logic/axiLiteSlave.sv
`timescale 1ns/10ps

module axiLiteSlave (
  input  logic                             aclk,
  input  logic                             rstN,
  // write address channel
  input  logic                             awvalid,
  output logic                             awready,
  input  logic [axiLitePkg::addrWidth-1:0] awaddr,
  input  logic [2:0]                       awprot,
  // write data channel
  input  logic                             wvalid,
  output logic                             wready,
  input  logic [axiLitePkg::dataWidth-1:0] wdata,
  input  logic [axiLitePkg::strbWidth-1:0] wstrb,
  // write response channel
  output logic                             bvalid,
  input  logic                             bready,
  output logic [1:0]                       bresp,
  // read address channel
  input  logic                             arvalid,
  output logic                             arready,
  input  logic [axiLitePkg::addrWidth-1:0] araddr,
  input  logic [2:0]                       arprot,
  // read data channel
  output logic                             rvalid,
  input  logic                             rready,
  output logic [axiLitePkg::dataWidth-1:0] rdata,
  output logic [1:0]                       rresp
);

  logic [axiLitePkg::addrWidth-1:0] wrAddr;
  logic [2:0]                       wrProt;
  logic [axiLitePkg::idxWidth-1:0]  wrIdx;
  logic                             wrErr;
  logic [axiLitePkg::addrWidth-1:0] rdAddr;
  logic [2:0]                       rdProt;
  logic [axiLitePkg::idxWidth-1:0]  rdIdx;
  logic                             rdErr;
  logic                             writeEn;
  logic [axiLitePkg::dataWidth-1:0] wrData;
  logic [axiLitePkg::strbWidth-1:0] wrStrb;
  logic                             readEn;

  axiLiteSlaveCtrl u_ctrl (
    .aclk    (aclk),
    .rstN    (rstN),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .arprot  (arprot),
    .rvalid  (rvalid),
    .rready  (rready),
    .rresp   (rresp),
    .wrAddr  (wrAddr),
    .wrProt  (wrProt),
    .wrIdx   (wrIdx),
    .wrErr   (wrErr),
    .rdAddr  (rdAddr),
    .rdProt  (rdProt),
    .rdErr   (rdErr),
    .writeEn (writeEn),
    .wrData  (wrData),
    .wrStrb  (wrStrb),
    .readEn  (readEn)
  );

  regAddrDecode u_wrDecode (
    .addr      (wrAddr),
    .prot      (wrProt),
    .regIdx    (wrIdx),
    .accessErr (wrErr)
  );

  regAddrDecode u_rdDecode (
    .addr      (rdAddr),
    .prot      (rdProt),
    .regIdx    (rdIdx),
    .accessErr (rdErr)
  );

  regBank u_regBank (
    .aclk    (aclk),
    .rstN    (rstN),
    .writeEn (writeEn),
    .wrIdx   (wrIdx),
    .wrData  (wrData),
    .wrStrb  (wrStrb),
    .readEn  (readEn),
    .rdIdx   (rdIdx),
    .rdErr   (rdErr),
    .rdata   (rdata)
  );

endmodule

//--- test/clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic aclk,
  output logic rstN
);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;                         // 10 ns period
  end

  // low for four rising edges, released in the drive slot
  initial begin
    rstN = 1'b0;
    repeat (4) @(posedge aclk);
    #1 rstN = 1'b1;
  end

endmodule

//--- test/axiLiteSlaveTb.sv
`timescale 1ns/10ps

module axiLiteSlaveTb;

  localparam int waitLimit = 40;                     // cycles before a wait gives up

  logic        aclk;
  logic        rstN;
  logic        awvalid;
  logic        awready;
  logic [7:0]  awaddr;
  logic [2:0]  awprot;
  logic        wvalid;
  logic        wready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic        arready;
  logic [7:0]  araddr;
  logic [2:0]  arprot;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  logic [31:0] model [0:7];                          // expected register contents
  int          errCount;
  int          timeoutCount;

  clockGen u_clockGen (.aclk(aclk), .rstN(rstN));

  axiLiteSlave u_axiLiteSlave (.*);

  // response per the register map rules
  function automatic logic [1:0] expectedResp(input logic [7:0] addr, input logic [2:0] prot,
                                              input logic isWrite);
    logic [2:0] idx;
    idx = addr[4:2];
    if (addr > 8'h1C || addr[1:0] != 2'b00) return axiLitePkg::respSlvErr;
    if (isWrite && idx == 3'd0) return axiLitePkg::respSlvErr;   // ID word
    if (idx >= 3'd4 && !prot[0]) return axiLitePkg::respSlvErr;
    return axiLitePkg::respOkay;
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] oldVal, input logic [31:0] newVal,
                                             input logic [3:0] strb);
    logic [31:0] result;
    result = oldVal;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) result[8*b +: 8] = newVal[8*b +: 8];
    end
    return result;
  endfunction

  task automatic compareValue(input string sigName, input logic [31:0] expVal,
                              input logic [31:0] actVal);
    assert (actVal === expVal) else begin
      errCount++;
      $display("Fail %s expected %h actual %h at %0t", sigName, expVal, actVal, $time);
    end
  endtask

  // order 0 sends AW first, 1 sends W first, 2 sends both together
  task automatic writeReg(input logic [7:0] addr, input logic [2:0] prot, input logic [31:0] data,
                          input logic [3:0] strb, input int order);
    logic       awDone;
    logic       wDone;
    logic       awHit;
    logic       wHit;
    logic       bDone;
    logic [1:0] expResp;
    int         delay;
    int         count;
    @(posedge aclk);                                 // start in the drive slot
    #1;
    expResp = expectedResp(addr, prot, 1'b1);
    delay = $urandom_range(0, 4);
    awDone = 1'b0;
    wDone = 1'b0;
    awaddr = addr;
    awprot = prot;
    wdata = data;
    wstrb = strb;
    awvalid = (order != 1);
    wvalid = (order != 0);
    count = 0;
    while (!(awDone && wDone) && count < waitLimit) begin
      @(negedge aclk);
      compareValue("bvalid", 32'(1'b0), 32'(bvalid));
      if (awDone) compareValue("awready", 32'(1'b0), 32'(awready));
      if (wDone) compareValue("wready", 32'(1'b0), 32'(wready));
      awHit = awvalid && awready;
      wHit = wvalid && wready;
      @(posedge aclk);
      #1;
      if (awHit) begin
        awvalid = 1'b0;
        awDone = 1'b1;
      end
      if (wHit) begin
        wvalid = 1'b0;
        wDone = 1'b1;
      end
      if (awDone && !wDone) wvalid = 1'b1;           // second half follows
      if (wDone && !awDone) awvalid = 1'b1;
      count++;
    end
    if (!(awDone && wDone)) begin
      timeoutCount++;
      $display("Timed out waiting for the write address or data handshake at %0t", $time);
      awvalid = 1'b0;
      wvalid = 1'b0;
      return;
    end
    // bvalid must already be up at the first sample after the later transfer
    bDone = 1'b0;
    bready = (delay == 0);
    count = 0;
    while (!bDone && count < waitLimit) begin
      @(negedge aclk);
      compareValue("bvalid", 32'(1'b1), 32'(bvalid));
      compareValue("bresp", 32'(expResp), 32'(bresp));
      compareValue("awready", 32'(1'b0), 32'(awready));
      compareValue("wready", 32'(1'b0), 32'(wready));
      bDone = bvalid && bready;
      @(posedge aclk);
      #1;
      count++;
      if (count >= delay) bready = 1'b1;
    end
    bready = 1'b0;
    if (!bDone) begin
      timeoutCount++;
      $display("Timed out waiting for the write response handshake at %0t", $time);
      return;
    end
    @(negedge aclk);
    compareValue("bvalid", 32'(1'b0), 32'(bvalid));
    compareValue("awready", 32'(1'b1), 32'(awready));
    compareValue("wready", 32'(1'b1), 32'(wready));
    if (expResp == axiLitePkg::respOkay) begin
      model[addr[4:2]] = mergeBytes(model[addr[4:2]], data, strb);
    end
  endtask

  task automatic readReg(input logic [7:0] addr, input logic [2:0] prot);
    logic        arDone;
    logic        rDone;
    logic        hit;
    logic [1:0]  expResp;
    logic [31:0] expData;
    int          delay;
    int          count;
    @(posedge aclk);                                 // start in the drive slot
    #1;
    expResp = expectedResp(addr, prot, 1'b0);
    expData = (expResp == axiLitePkg::respOkay) ? model[addr[4:2]] : 32'h0;
    delay = $urandom_range(0, 4);
    araddr = addr;
    arprot = prot;
    arvalid = 1'b1;
    arDone = 1'b0;
    count = 0;
    while (!arDone && count < waitLimit) begin
      @(negedge aclk);
      compareValue("rvalid", 32'(1'b0), 32'(rvalid));
      hit = arvalid && arready;
      @(posedge aclk);
      #1;
      if (hit) begin
        arvalid = 1'b0;
        arDone = 1'b1;
      end
      count++;
    end
    if (!arDone) begin
      timeoutCount++;
      $display("Timed out waiting for the read address handshake at %0t", $time);
      arvalid = 1'b0;
      return;
    end
    rDone = 1'b0;
    rready = (delay == 0);
    count = 0;
    while (!rDone && count < waitLimit) begin
      @(negedge aclk);
      compareValue("rvalid", 32'(1'b1), 32'(rvalid));
      compareValue("rdata", expData, rdata);
      compareValue("rresp", 32'(expResp), 32'(rresp));
      compareValue("arready", 32'(1'b0), 32'(arready));
      rDone = rvalid && rready;
      @(posedge aclk);
      #1;
      count++;
      if (count >= delay) rready = 1'b1;
    end
    rready = 1'b0;
    if (!rDone) begin
      timeoutCount++;
      $display("Timed out waiting for the read data handshake at %0t", $time);
      return;
    end
    @(negedge aclk);
    compareValue("rvalid", 32'(1'b0), 32'(rvalid));
    compareValue("arready", 32'(1'b1), 32'(arready));
  endtask

  task automatic readAllRegs();
    for (int i = 0; i < 8; i++) begin
      readReg(8'(i * 4), 3'b001);
    end
  endtask

  initial begin
    int idx;
    int count;
    awvalid = 1'b0;
    awaddr = '0;
    awprot = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    arprot = '0;
    rready = 1'b0;
    errCount = 0;
    timeoutCount = 0;
    void'($urandom(42550));
    model[0] = axiLitePkg::idValue;
    for (int i = 1; i < 8; i++) model[i] = axiLitePkg::resetValue;

    count = 0;
    while (rstN !== 1'b1 && count < waitLimit) begin
      @(posedge aclk);
      count++;
    end
    if (rstN !== 1'b1) begin
      timeoutCount++;
      $display("Timed out waiting for reset to be released");
    end
    #1;
    @(negedge aclk);
    compareValue("bvalid", 32'(1'b0), 32'(bvalid));
    compareValue("rvalid", 32'(1'b0), 32'(rvalid));
    compareValue("awready", 32'(1'b1), 32'(awready));
    compareValue("wready", 32'(1'b1), 32'(wready));
    compareValue("arready", 32'(1'b1), 32'(arready));
    readAllRegs();

    // full words to every register in all three channel orders
    for (int i = 1; i < 8; i++) begin
      for (int order = 0; order < 3; order++) begin
        writeReg(8'(i * 4), 3'b001, $urandom, 4'hF, order);
        readReg(8'(i * 4), 3'b001);
      end
    end

    // partial strobes
    repeat (14) begin
      idx = $urandom_range(1, 7);
      writeReg(8'(idx * 4), 3'b001, $urandom, 4'($urandom_range(0, 15)), $urandom_range(0, 2));
      readReg(8'(idx * 4), 3'b001);
    end

    // ID word, out of map and misaligned
    writeReg(8'h00, 3'b001, $urandom, 4'hF, 0);
    writeReg(8'h20, 3'b001, $urandom, 4'hF, 1);
    writeReg(8'hFC, 3'b001, $urandom, 4'hF, 2);
    writeReg(8'h09, 3'b001, $urandom, 4'hF, 0);
    writeReg(8'h16, 3'b001, $urandom, 4'h3, 2);
    readAllRegs();
    readReg(8'h20, 3'b001);
    readReg(8'hE0, 3'b001);
    readReg(8'h0D, 3'b001);

    // unprivileged access to the upper half
    readReg(8'h04, 3'b000);
    for (int i = 4; i < 8; i++) begin
      writeReg(8'(i * 4), 3'b000, $urandom, 4'hF, i % 3);
      writeReg(8'(i * 4), 3'b110, $urandom, 4'hF, 2);
      readReg(8'(i * 4), 3'b000);
      readReg(8'(i * 4), 3'b010);
    end
    readAllRegs();
    for (int i = 4; i < 8; i++) begin
      writeReg(8'(i * 4), 3'b001, $urandom, 4'hF, i % 3);
      readReg(8'(i * 4), 3'b001);
    end
    readAllRegs();

    $display("Errors: %0d failed checks, %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- axiLiteRegs.f
logic/axiLitePkg.sv
logic/regAddrDecode.sv
logic/regBank.sv
logic/axiLiteSlaveCtrl.sv
logic/axiLiteSlave.sv
test/clockGen.sv
test/axiLiteSlaveTb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module axiLiteSlaveTb \
  --Mdir "$buildDir" \
  -o axiLiteSlaveTb \
  -f axiLiteRegs.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/axiLiteSlaveTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "simulator exited with status $simStatus"
  exit 1
fi

if grep -q "^Simulation passed$" "$logFile"; then
  exit 0
fi
exit 1
